//--- logic/imul_pkg.sv
/*
  shared constants and types of the multiply farm
  lane_idx_w must cover num_lanes, and num_lanes is assumed to be a power of two
*/

package imul_pkg;

  // ------------------------------------------------------------------------
  // farm geometry
  // ------------------------------------------------------------------------

  // number of iterative lanes behind the dispatcher
  localparam int num_lanes = 4;

  // index of one lane, also the width of the round-robin pointer
  localparam int lane_idx_w = 2;

  // ------------------------------------------------------------------------
  // datapath widths
  // ------------------------------------------------------------------------

  // two's-complement operand width
  localparam int opnd_w = 32;

  // full product width, twice the operand
  localparam int prod_w = 64;

  // iteration counter, wide enough to reach opnd_w-1
  localparam int count_w = 6;

  // caller tag, passed through the lane untouched
  typedef logic [3:0] tag_t;

endpackage

//--- logic/imul_lane_if.sv
/*
  one bundle per lane, shared by dispatcher, lane and collector
  done/result/result_tag hold until ack, start is a single-cycle strobe
*/

`timescale 1ns/10ps

interface imul_lane_if;
  import imul_pkg::*;

  // request side, driven by the dispatcher
  logic              start;
  logic [opnd_w-1:0] a;
  logic [opnd_w-1:0] b;
  tag_t              tag;

  // lane status
  logic              busy;
  logic              done;

  // response side, held by the lane until ack
  logic [prod_w-1:0] result;
  tag_t              result_tag;
  logic              ack;

  modport dispatch (output start, output a, output b, output tag, input busy);

  modport lane (
    input  start, input  a, input  b, input  tag, input  ack,
    output busy, output done, output result, output result_tag
  );

  modport collect (input done, input result, input result_tag, output ack);

endinterface

//--- logic/imul_dispatch.sv
/*
  combinational request steering, no back-pressure toward the source
  a request seen while every lane is busy is lost and flagged on req_drop
*/

`timescale 1ns/10ps

module imul_dispatch (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_valid,
  input  logic [imul_pkg::opnd_w-1:0] req_a,
  input  logic [imul_pkg::opnd_w-1:0] req_b,
  input  imul_pkg::tag_t             req_tag,
  output logic                       req_drop,
  imul_lane_if.dispatch              lanes [imul_pkg::num_lanes-1:0]
);
  import imul_pkg::*;

  // per-lane status and strobes, flattened out of the interface array
  logic [num_lanes-1:0] busy_vec;
  logic [num_lanes-1:0] start_vec;

  // ------------------------------------------------------------------------
  // lane fan-out
  // ------------------------------------------------------------------------

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    assign busy_vec[i] = lanes[i].busy;
    assign lanes[i].start = start_vec[i];
    // operands go to every lane, only the started one latches them
    assign lanes[i].a = req_a;
    assign lanes[i].b = req_b;
    assign lanes[i].tag = req_tag;
  end

  // ------------------------------------------------------------------------
  // lowest idle lane
  // ------------------------------------------------------------------------

  always_comb begin
    logic found;
    found = 1'b0;
    start_vec = '0;
    for (int i = 0; i < num_lanes; i++) begin
      // first free lane wins, higher ones are left alone
      if (req_valid && !found && !busy_vec[i]) begin
        start_vec[i] = 1'b1;
        found = 1'b1;
      end
    end
  end

  // every lane busy, request goes nowhere
  assign req_drop = req_valid && (&busy_vec);

endmodule

//--- logic/imul_iterative.sv
/*
  signed shift-add multiplier lane, one multiplier bit per cycle
  CALC stops once the shifted multiplier is zero, so latency follows |b|
*/

`timescale 1ns/10ps

module imul_iterative (
  input  logic      clk,
  input  logic      reset,
  imul_lane_if.lane lane
);
  import imul_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_t;

  state_t state_q;
  state_t state_d;

  // ------------------------------------------------------------------------
  // datapath registers
  // ------------------------------------------------------------------------

  // multiplicand magnitude, shifted left every CALC cycle
  logic [prod_w-1:0] mcand_q;
  // multiplier magnitude, shifted right every CALC cycle
  logic [opnd_w-1:0] mplier_q;
  // partial product
  logic [prod_w-1:0] acc_q;
  logic              sign_a_q;
  logic              sign_b_q;
  tag_t              tag_q;

  // control side
  logic [count_w-1:0] count_q;

  // control strobes into the datapath
  logic load_en;
  logic calc_en;
  logic calc_last;

  // datapath wires
  logic              sign_a;
  logic              sign_b;
  logic [opnd_w-1:0] mag_a;
  logic [opnd_w-1:0] mag_b;
  logic [opnd_w-1:0] mplier_next;
  logic [prod_w-1:0] acc_next;
  logic              neg_result;

  // ------------------------------------------------------------------------
  // operand conditioning
  // ------------------------------------------------------------------------

  // sign is the top bit of each operand
  assign sign_a = lane.a[opnd_w-1];
  assign sign_b = lane.b[opnd_w-1];

  // two's-complement magnitude
  // most negative input maps onto 2^31, still correct as unsigned
  assign mag_a = sign_a ? (~lane.a + 1'b1) : lane.a;
  assign mag_b = sign_b ? (~lane.b + 1'b1) : lane.b;

  // ------------------------------------------------------------------------
  // shift-add step
  // ------------------------------------------------------------------------

  assign mplier_next = mplier_q >> 1;

  // add the shifted multiplicand only when the low multiplier bit is set
  assign acc_next = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

  always_ff @(posedge clk) begin
    if (load_en) begin
      mcand_q  <= {{(prod_w - opnd_w){1'b0}}, mag_a};
      mplier_q <= mag_b;
      acc_q    <= '0;
      sign_a_q <= sign_a;
      sign_b_q <= sign_b;
      tag_q    <= lane.tag;
    end else if (calc_en) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_next;
      acc_q    <= acc_next;
    end
  end

  // ------------------------------------------------------------------------
  // control
  // ------------------------------------------------------------------------

  // start is only honoured from IDLE
  assign load_en = (state_q == IDLE) && lane.start;
  assign calc_en = (state_q == CALC);

  // early exit on an empty multiplier, hard stop after opnd_w steps
  assign calc_last = (mplier_next == '0) || (count_q == count_w'(opnd_w - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (lane.start) begin
          state_d = CALC;
        end
      end
      CALC: begin
        if (calc_last) begin
          state_d = DONE;
        end
      end
      DONE: begin
        // back to idle on the edge that sees the ack
        if (lane.ack) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (load_en) begin
        count_q <= '0;
      end else if (calc_en) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // lane outputs
  // ------------------------------------------------------------------------

  // product is negative when exactly one operand was
  assign neg_result = sign_a_q ^ sign_b_q;

  // busy covers CALC and DONE, so no new start lands on a held result
  assign lane.busy = (state_q != IDLE);
  assign lane.done = (state_q == DONE);

  // registers are frozen in DONE, so result stays stable until ack
  assign lane.result = neg_result ? (~acc_q + 1'b1) : acc_q;
  assign lane.result_tag = tag_q;

endmodule

//--- logic/imul_collect.sv
/*
  round-robin collector over finished lanes, one response per cycle
  ack is combinational, the response appears one cycle after it
*/

`timescale 1ns/10ps

module imul_collect (
  input  logic                        clk,
  input  logic                        reset,
  imul_lane_if.collect                lanes [imul_pkg::num_lanes-1:0],
  output logic                        resp_valid,
  output logic [imul_pkg::prod_w-1:0] resp_result,
  output imul_pkg::tag_t              resp_tag
);
  import imul_pkg::*;

  // lane status and payload, flattened out of the interface array
  logic [num_lanes-1:0] done_vec;
  logic [prod_w-1:0]    result_arr [num_lanes];
  tag_t                 tag_arr [num_lanes];

  // grant of this cycle
  logic [num_lanes-1:0]  grant_vec;
  logic [lane_idx_w-1:0] grant_idx;
  logic                  grant_any;

  // last lane granted, search starts just after it
  logic [lane_idx_w-1:0] last_q;

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    assign done_vec[i] = lanes[i].done;
    assign result_arr[i] = lanes[i].result;
    assign tag_arr[i] = lanes[i].result_tag;
    assign lanes[i].ack = grant_vec[i];
  end

  // ------------------------------------------------------------------------
  // round-robin search
  // ------------------------------------------------------------------------

  always_comb begin
    logic [lane_idx_w-1:0] cand;
    cand = last_q;
    grant_vec = '0;
    grant_idx = '0;
    grant_any = 1'b0;
    // wraps naturally, the last lane granted is tried last
    for (int off = 1; off <= num_lanes; off++) begin
      cand = last_q + lane_idx_w'(off);
      if (!grant_any && done_vec[cand]) begin
        grant_vec[cand] = 1'b1;
        grant_idx = cand;
        grant_any = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // response register
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_valid <= 1'b0;
      last_q     <= '0;
    end else begin
      resp_valid <= grant_any;
      if (grant_any) begin
        last_q <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_any) begin
      resp_result <= result_arr[grant_idx];
      resp_tag    <= tag_arr[grant_idx];
    end
  end

endmodule

//--- logic/imul_farm.sv
/*
  signed 32x32 multiply farm, four iterative lanes
  no back-pressure, requests with all lanes busy are dropped
  results leave in completion order, identified by tag
*/

`timescale 1ns/10ps

module imul_farm (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               req_valid,
  input  logic signed [imul_pkg::opnd_w-1:0] req_a,
  input  logic signed [imul_pkg::opnd_w-1:0] req_b,
  input  imul_pkg::tag_t                     req_tag,
  output logic                               req_drop,
  output logic                               resp_valid,
  output logic        [imul_pkg::prod_w-1:0] resp_result,
  output imul_pkg::tag_t                     resp_tag
);
  import imul_pkg::*;

  // one bundle per lane
  imul_lane_if lane_bus [num_lanes-1:0] ();

  // ------------------------------------------------------------------------
  // request steering
  // ------------------------------------------------------------------------

  imul_dispatch u_dispatch (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_a     (req_a),
    .req_b     (req_b),
    .req_tag   (req_tag),
    .req_drop  (req_drop),
    .lanes     (lane_bus)
  );

  // ------------------------------------------------------------------------
  // multiplier lanes
  // ------------------------------------------------------------------------

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    imul_iterative u_lane (
      .clk   (clk),
      .reset (reset),
      .lane  (lane_bus[i])
    );
  end

  // response arbitration and output register
  imul_collect u_collect (
    .clk         (clk),
    .reset       (reset),
    .lanes       (lane_bus),
    .resp_valid  (resp_valid),
    .resp_result (resp_result),
    .resp_tag    (resp_tag)
  );

endmodule

//--- verification/imul_farm_props.sv
/*
  handshake checks between the lanes and the collector, bound into imul_collect
*/

`timescale 1ns/10ps

module imul_farm_props (
  input logic                           clk,
  input logic                           reset,
  input logic [imul_pkg::num_lanes-1:0] done_vec,
  input logic [imul_pkg::num_lanes-1:0] grant_vec,
  input logic                           resp_valid
);
  import imul_pkg::*;

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    // ack only toward a finished lane
    ack_needs_done: assert property (@(posedge clk) disable iff (reset)
      grant_vec[i] |-> done_vec[i])
      else $error("ack raised toward lane %0d while its done is low", i);

    // a finished lane waits for its ack
    done_holds: assert property (@(posedge clk) disable iff (reset)
      done_vec[i] && !grant_vec[i] |=> done_vec[i])
      else $error("lane %0d dropped done before it was acknowledged", i);
  end

  one_ack: assert property (@(posedge clk) disable iff (reset) $onehot0(grant_vec))
    else $error("more than one lane acknowledged in one cycle");

  // response register trails the ack by exactly one cycle
  resp_after_ack: assert property (@(posedge clk) disable iff (reset)
    (|grant_vec) |=> resp_valid)
    else $error("ack was not followed by resp_valid");
  no_resp_without_ack: assert property (@(posedge clk) disable iff (reset)
    !(|grant_vec) |=> !resp_valid)
    else $error("resp_valid raised without an ack one cycle earlier");

endmodule

bind imul_collect imul_farm_props u_props (
  .clk        (clk),
  .reset      (reset),
  .done_vec   (done_vec),
  .grant_vec  (grant_vec),
  .resp_valid (resp_valid)
);

//--- verification/imul_farm_tb.sv
/*
  directed tests with a tag scoreboard, responses may return in any order
  tags wrap at 16, so no more than four requests are kept outstanding
*/

`timescale 1ns/10ps

module imul_farm_tb;
  import imul_pkg::*;

  localparam int clk_period = 100;
  localparam int num_tests = 6;
  localparam int timeout_cycles = num_tests * 16 * 40;
  localparam int drain_limit = 200;

  logic                     clk;
  logic                     reset;
  logic                     req_valid;
  logic signed [opnd_w-1:0] req_a;
  logic signed [opnd_w-1:0] req_b;
  tag_t                     req_tag;
  logic                     req_drop;
  logic                     resp_valid;
  logic [prod_w-1:0]        resp_result;
  tag_t                     resp_tag;

  integer seed = 32'h1af89acd;
  int errors = 0;
  int tests_run = 0;
  int cycle_count = 0;
  int accept_count = 0;
  int drop_count = 0;
  int resp_count = 0;
  tag_t next_tag = '0;
  tag_t last_tag;
  logic signed [prod_w-1:0] last_prod;

  // accepted requests still waiting for their product
  tag_t exp_tag_q [$];
  logic signed [prod_w-1:0] exp_prod_q [$];

  imul_farm uut (
    .clk(clk), .reset(reset), .req_valid(req_valid), .req_a(req_a), .req_b(req_b),
    .req_tag(req_tag), .req_drop(req_drop), .resp_valid(resp_valid),
    .resp_result(resp_result), .resp_tag(resp_tag)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // full-width signed product, sign extension does the work
  function automatic logic signed [prod_w-1:0] expected_product(
    input logic signed [opnd_w-1:0] a, input logic signed [opnd_w-1:0] b);
    logic signed [prod_w-1:0] wide_a;
    logic signed [prod_w-1:0] wide_b;
    wide_a = a;
    wide_b = b;
    return wide_a * wide_b;
  endfunction

  task automatic compare_product(input string name, input logic signed [prod_w-1:0] got,
                                 input logic signed [prod_w-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("error at %0t: %s was %0d, should be %0d", $time, what, got, exp);
    end
  endtask

  // ------------------------------------------------------------------------
  // monitor and scoreboard, sampled before the edge updates anything
  // ------------------------------------------------------------------------

  always @(posedge clk) begin
    int idx;
    if (!reset) begin
      if (req_valid && !req_drop) begin
        exp_tag_q.push_back(req_tag);
        exp_prod_q.push_back(expected_product(req_a, req_b));
        accept_count++;
      end
      if (req_valid && req_drop) begin
        drop_count++;
      end
      if (req_drop && !req_valid) begin
        errors++;
        $display("error at %0t: req_drop raised with no request", $time);
      end
      if (resp_valid) begin
        idx = -1;
        foreach (exp_tag_q[i]) begin
          if (idx < 0 && exp_tag_q[i] == resp_tag) begin
            idx = i;
          end
        end
        if (idx < 0) begin
          errors++;
          $display("error at %0t: tag %0d returned but not outstanding", $time, resp_tag);
        end else begin
          compare_product("resp_result", resp_result, exp_prod_q[idx]);
          exp_tag_q.delete(idx);
          exp_prod_q.delete(idx);
        end
        resp_count++;
        last_tag = resp_tag;
        last_prod = resp_result;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run went past %0d cycles", timeout_cycles);
      $display("tests failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------------

  // request stays up until the next call or release_bus
  task automatic issue_request(input logic signed [opnd_w-1:0] a,
                               input logic signed [opnd_w-1:0] b);
    @(negedge clk);
    req_valid = 1'b1;
    req_a = a;
    req_b = b;
    req_tag = next_tag;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic release_bus();
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_tag_q.size() != 0 && waited < drain_limit) begin
      @(negedge clk);
      waited++;
    end
    if (exp_tag_q.size() != 0) begin
      errors++;
      $display("error at %0t: %0d responses never came back", $time, exp_tag_q.size());
      exp_tag_q.delete();
      exp_prod_q.delete();
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------

  task automatic test_idle();
    int start_errors;
    start_errors = errors;
    repeat (8) begin
      @(negedge clk);
      if (req_drop || resp_valid) begin
        errors++;
        $display("error at %0t: outputs active with no request", $time);
      end
    end
    end_test("idle after reset", start_errors);
  endtask

  task automatic single_case(input logic signed [opnd_w-1:0] a,
                             input logic signed [opnd_w-1:0] b);
    tag_t tag;
    tag = next_tag;
    issue_request(a, b);
    release_bus();
    wait_drain();
    compare_tag("resp_tag", last_tag, tag);
  endtask

  task automatic test_single();
    int start_errors;
    start_errors = errors;
    single_case(32'sd3, 32'sd7);
    single_case(-32'sd5, 32'sd9);
    single_case(32'sd12345, -32'sd678);
    single_case(-32'sd1, -32'sd1);
    single_case(32'sd0, -32'sd99999);
    single_case(32'sd1, 32'sh8000_0000);
    single_case(-32'sd1, 32'sh7fff_ffff);
    // most negative squared lands exactly on 2^62
    single_case(32'sh8000_0000, 32'sh8000_0000);
    compare_product("resp_result", last_prod, 64'sh4000_0000_0000_0000);
    end_test("single requests", start_errors);
  endtask

  task automatic test_burst();
    int start_errors;
    int drops_before;
    start_errors = errors;
    drops_before = drop_count;
    repeat (num_lanes) issue_request($random(seed), $random(seed));
    release_bus();
    wait_drain();
    check_count("drops in burst", drop_count - drops_before, 0);
    end_test("back-to-back burst", start_errors);
  endtask

  // b of -2^31 keeps each lane in CALC for all 32 steps
  task automatic test_drop();
    int start_errors;
    int drops_before;
    int resp_before;
    start_errors = errors;
    drops_before = drop_count;
    resp_before = resp_count;
    repeat (num_lanes) issue_request($random(seed), 32'sh8000_0000);
    issue_request($random(seed), $random(seed));
    release_bus();
    wait_drain();
    check_count("drops with all lanes busy", drop_count - drops_before, 1);
    check_count("responses after drop", resp_count - resp_before, num_lanes);
    end_test("drop when full", start_errors);
  endtask

  task automatic test_overlap();
    int start_errors;
    int accept_before;
    int resp_before;
    start_errors = errors;
    accept_before = accept_count;
    resp_before = resp_count;
    // shrinking b bit length, so all four reach DONE on the same edge
    issue_request($random(seed), 32'sd8);
    issue_request($random(seed), 32'sd4);
    issue_request($random(seed), 32'sd2);
    issue_request($random(seed), 32'sd1);
    release_bus();
    wait_drain();
    repeat (num_lanes) issue_request($random(seed), 32'sd3);
    release_bus();
    wait_drain();
    check_count("accepted requests", accept_count - accept_before, 2 * num_lanes);
    check_count("responses", resp_count - resp_before, accept_count - accept_before);
    end_test("overlapping completions", start_errors);
  endtask

  task automatic test_reuse();
    int start_errors;
    int drops_before;
    start_errors = errors;
    drops_before = drop_count;
    for (int n = 0; n < 64; n++) begin
      // hold off while every lane may still be occupied
      while (exp_tag_q.size() >= num_lanes) begin
        @(negedge clk);
      end
      issue_request($random(seed), $random(seed));
      release_bus();
      repeat ($random(seed) & 32'd3) @(negedge clk);
    end
    wait_drain();
    check_count("drops in stream", drop_count - drops_before, 0);
    end_test("lane reuse stream", start_errors);
  endtask

  initial begin
    reset = 1'b1;
    req_valid = 1'b0;
    req_a = '0;
    req_b = '0;
    req_tag = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    test_idle();
    test_single();
    test_burst();
    test_drop();
    test_overlap();
    test_reuse();
    $display("%0d tests, %0d accepted, %0d dropped, %0d responses, %0d errors",
             tests_run, accept_count, drop_count, resp_count, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- imul_farm.f
logic/imul_pkg.sv
logic/imul_lane_if.sv
logic/imul_dispatch.sv
logic/imul_iterative.sv
logic/imul_collect.sv
logic/imul_farm.sv
verification/imul_farm_props.sv
verification/imul_farm_tb.sv

//--- Bender.yml
package:
  name: imul_farm

sources:
  # synthesizable design, package first
  - logic/imul_pkg.sv
  - logic/imul_lane_if.sv
  - logic/imul_dispatch.sv
  - logic/imul_iterative.sv
  - logic/imul_collect.sv
  - logic/imul_farm.sv

  # simulation only
  - target: test
    files:
      - verification/imul_farm_props.sv
      - verification/imul_farm_tb.sv
